// File: key_extract_top.f
key_extract_pkg.sv
config_table.sv
ctrl_write_fsm.sv
key_extractor.sv
key_extract_top.sv
key_extract_sva.sv
tb_key_extract_top.sv

// File: run.sh
#!/bin/sh
# builds with Verilator, runs, and looks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_key_extract_top -f key_extract_top.f -o sim_key_extract

out=$(./obj_dir/sim_key_extract || true)
echo "$out"
echo "$out" | grep -q "^Testbench passed$"

// File: tb_key_extract_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_key_extract_top;

	localparam logic [4:0] STAGE = 5'd0;
	localparam logic [2:0] EXID  = 3'd1;

	logic                        clk;
	logic                        rst_n;
	key_extract_pkg::ctrl_beat_t ctrl_in;
	key_extract_pkg::ctrl_beat_t ctrl_out;
	key_extract_pkg::pkt_in_t    pkt_in;
	key_extract_pkg::pkt_out_t   pkt_out;

	logic [31:0] lfsr;
	int          errors = 0;
	int          checks = 0;
	int          seen = 0;
	int          tests = 0;
	int          failed = 0;
	int          test_err = 0;
	int          test_seen = 0;
	logic        timed_out = 1'b0;
	int          written [$];

	// model of the control FSM, both tables and the lookup pipeline
	logic [1:0]                  m_state;
	logic                        m_first;
	logic [7:0]                  m_idx;
	logic                        p_off;
	logic                        p_mask;
	logic [7:0]                  p_idx;
	logic [191:0]                p_entry;
	logic [17:0]                 off_mem [32];
	logic [191:0]                mask_mem [32];
	key_extract_pkg::ctrl_beat_t exp_ctrl;
	logic                        exp_fwd;
	logic [1:0]                  pv;
	logic [1023:0]               pphv [2];
	logic [191:0]                pkey [2];

	key_extract_top #(
		.STAGE_ID     (STAGE),
		.KEY_EX_ID    (EXID),
		.TABLE_ADDR_W (5)
	) i_key_extract_top (
		.clk      (clk),
		.rst_n    (rst_n),
		.ctrl_in  (ctrl_in),
		.pkt_in   (pkt_in),
		.ctrl_out (ctrl_out),
		.pkt_out  (pkt_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// galois lfsr, one step per bit
	function automatic logic [1023:0] take_bits(input int n);
		logic [1023:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[i] = lfsr[0];
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// byte 0 of the beat is the top byte of the entry
	function automatic logic [191:0] entry_of(input logic [511:0] d);
		logic [191:0] e;
		for (int i = 0; i < 24; i++) begin
			e[191 - 8 * i -: 8] = d[8 * i +: 8];
		end
		return e;
	endfunction

	function automatic logic [191:0] model_key(input logic [1023:0] v, input logic [17:0] o,
		input logic [191:0] m);
		logic [191:0] k;
		k = {v[640 + 48 * o[17:15] +: 48], v[640 + 48 * o[14:12] +: 48],
			v[384 + 32 * o[11:9] +: 32], v[384 + 32 * o[8:6] +: 32],
			v[256 + 16 * o[5:3] +: 16], v[256 + 16 * o[2:0] +: 16]};
		return k & m;
	endfunction

	function automatic key_extract_pkg::ctrl_beat_t random_beat();
		key_extract_pkg::ctrl_beat_t b;
		b.data  = 512'(take_bits(512));
		b.user  = 128'(take_bits(128));
		b.keep  = 64'(take_bits(64));
		b.valid = 1'(take_bits(1));
		b.last  = 1'(take_bits(1));
		return b;
	endfunction

	function automatic key_extract_pkg::ctrl_beat_t header(input logic [15:0] flag,
		input logic [4:0] stage, input logic [2:0] exid, input logic [3:0] resv,
		input logic [7:0] index);
		key_extract_pkg::ctrl_beat_t b;
		b = random_beat();
		b.data[key_extract_pkg::HDR_FLAG_LSB +: 16] = flag;
		b.data[key_extract_pkg::HDR_MODID_LSB +: 8] = {stage, exid};
		b.data[key_extract_pkg::HDR_RESV_LSB +: 4] = resv;
		b.data[key_extract_pkg::HDR_INDEX_LSB +: 8] = index;
		b.valid = 1'b1;
		b.last = 1'b0;
		return b;
	endfunction

	function automatic key_extract_pkg::pkt_in_t random_pkt(input logic valid);
		key_extract_pkg::pkt_in_t p;
		p.phv = key_extract_pkg::phv_t'(take_bits(1024));
		p.vlan = 12'(take_bits(12));
		p.valid = valid;
		return p;
	endfunction

	task automatic drive(input key_extract_pkg::ctrl_beat_t c,
		input key_extract_pkg::pkt_in_t p);
		@(posedge clk);
		ctrl_in <= c;
		pkt_in <= p;
	endtask

	// header beat, then n data beats with the odd valid-low gap
	task automatic write_table(input logic [3:0] resv, input logic [7:0] start, input int n,
		input logic ones);
		key_extract_pkg::ctrl_beat_t b;
		drive(header(key_extract_pkg::CTRL_FLAG, STAGE, EXID, resv, start), '0);
		for (int i = 0; i < n; i++) begin
			if (2'(take_bits(2)) == 2'd0) begin
				b = random_beat();
				b.valid = 1'b0;
				drive(b, '0);
			end
			b = random_beat();
			if (ones) begin
				b.data[191:0] = '1;
			end
			b.valid = 1'b1;
			b.last = (i == n - 1);
			written.push_back((int'(start) + i) % 32);
			drive(b, '0);
		end
	endtask

	// negative address picks a random vlan
	task automatic lookup(input int addr);
		key_extract_pkg::pkt_in_t p;
		p = random_pkt(1'b1);
		if (addr >= 0) begin
			p.vlan[8:4] = 5'(addr);
		end
		drive('0, p);
	endtask

	task automatic drain(input string what);
		drive('0, '0);
		for (int i = 0; i < 20 && pv != 2'b00; i++) begin
			@(posedge clk);
		end
		if (pv != 2'b00) begin
			$display("timeout: lookups of the %s test never left the pipeline", what);
			timed_out = 1'b1;
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors != test_err) begin
			failed++;
		end
		$display("test %0d %s: %s, %0d errors, %0d lookups checked", tests, name,
			(errors == test_err) ? "ok" : "FAILED", errors - test_err, seen - test_seen);
		test_err = errors;
		test_seen = seen;
	endtask

	// ====================
	// reference model
	// ====================
	initial begin
		logic [4:0]   a;
		logic [17:0]  r_off;
		logic [191:0] r_mask;
		logic         hit;
		forever begin
			@(negedge clk);
			if (!rst_n) begin
				checks++;
				assert (!ctrl_out.valid && !pkt_out.phv_valid && !pkt_out.key_valid) else begin
					errors++;
					$display("ERR %0t: output valid high during reset", $time);
				end
				m_state = 2'd0;
				m_first = 1'b0;
				m_idx = '0;
				p_off = 1'b0;
				p_mask = 1'b0;
				exp_fwd = 1'b0;
				pv = 2'b00;
				for (int i = 0; i < 32; i++) begin
					off_mem[i] = '0;
					mask_mem[i] = '0;
				end
			end else begin
				checks += 2;
				assert (exp_fwd ? (ctrl_out == exp_ctrl) : !ctrl_out.valid) else begin
					errors++;
					$display("ERR %0t: ctrl_out valid %b data %h, expected fwd %b data %h",
						$time, ctrl_out.valid, ctrl_out.data, exp_fwd, exp_ctrl.data);
				end
				assert (pkt_out.phv_valid == pv[1] && pkt_out.key_valid == pv[1]) else begin
					errors++;
					$display("ERR %0t: pkt_out valids %b/%b, expected %b", $time,
						pkt_out.phv_valid, pkt_out.key_valid, pv[1]);
				end
				if (pv[1]) begin
					seen++;
					checks += 2;
					assert (pkt_out.phv == pphv[1]) else begin
						errors++;
						$display("ERR %0t: phv changed on its way through", $time);
					end
					assert (pkt_out.key == pkey[1]) else begin
						errors++;
						$display("ERR %0t: key %h, expected %h", $time, pkt_out.key, pkey[1]);
					end
				end
				// table read sees memory before this edge's write
				a = pkt_in.vlan[key_extract_pkg::VLAN_ADDR_LSB +: 5];
				r_off = off_mem[a];
				r_mask = mask_mem[a];
				if (p_off) begin
					off_mem[p_idx[4:0]] = p_entry[191:174];
				end
				if (p_mask) begin
					mask_mem[p_idx[4:0]] = p_entry;
				end
				p_off = 1'b0;
				p_mask = 1'b0;
				exp_fwd = 1'b0;
				hit = ctrl_in.valid
					&& ctrl_in.data[key_extract_pkg::HDR_FLAG_LSB +: 16] == key_extract_pkg::CTRL_FLAG
					&& ctrl_in.data[key_extract_pkg::HDR_MODID_LSB +: 8] == {STAGE, EXID};
				if (m_state == 2'd0) begin
					if (hit) begin
						m_idx = ctrl_in.data[key_extract_pkg::HDR_INDEX_LSB +: 8];
						m_first = 1'b1;
						m_state = (ctrl_in.data[key_extract_pkg::HDR_RESV_LSB +: 4] == 4'd0)
							? 2'd1 : 2'd2;
					end else begin
						exp_fwd = 1'b1;
						exp_ctrl = ctrl_in;
					end
				end else if (ctrl_in.valid) begin
					p_idx = m_first ? m_idx : m_idx + 8'd1;
					m_idx = p_idx;
					m_first = 1'b0;
					p_entry = entry_of(ctrl_in.data);
					p_off = (m_state == 2'd1);
					p_mask = (m_state == 2'd2);
					if (ctrl_in.last) begin
						m_state = 2'd0;
					end
				end
				pv = {pv[0], pkt_in.valid};
				pphv[1] = pphv[0];
				pkey[1] = pkey[0];
				pphv[0] = pkt_in.phv;
				pkey[0] = model_key(pkt_in.phv, r_off, r_mask);
			end
		end
	end

	// ====================
	// tests
	// ====================
	initial begin
		key_extract_pkg::ctrl_beat_t b;
		logic [1:0]  kind;
		logic [15:0] flag;
		logic [4:0]  stage;
		logic [2:0]  exid;
		logic [7:0]  start;
		int          n;
		lfsr = 32'had96ee02;
		rst_n = 1'b0;
		ctrl_in = '0;
		pkt_in = '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		// nothing configured yet, keys come back zero
		repeat (3) drive('0, '0);
		for (int i = 0; i < 8; i++) begin
			lookup(-1);
		end
		drain("reset");
		end_test("reset");

		for (int i = 0; i < 40; i++) begin
			kind = 2'(take_bits(2));
			flag = 16'(take_bits(16));
			stage = 5'(take_bits(5));
			exid = 3'(take_bits(3));
			if (flag == key_extract_pkg::CTRL_FLAG) begin
				flag = ~flag;
			end
			if (stage == STAGE) begin
				stage = ~stage;
			end
			if (exid == EXID) begin
				exid = ~exid;
			end
			b = header((kind == 2'd0) ? flag : key_extract_pkg::CTRL_FLAG,
				(kind == 2'd1) ? stage : STAGE, (kind == 2'd2) ? exid : EXID,
				4'(take_bits(4)), 8'(take_bits(8)));
			// kind 3 is a correct header with valid low
			b.valid = (kind == 2'd3) ? 1'b0 : (1'(take_bits(1)) | 1'(take_bits(1)));
			b.last = 1'(take_bits(1));
			drive(b, '0);
		end
		drain("forward");
		end_test("forward");

		write_table(4'hf, 8'd0, 32, 1'b1);
		written.delete();
		start = 8'(take_bits(8));
		n = 3 + int'(2'(take_bits(2)));
		write_table(4'd0, start, n, 1'b0);
		repeat (2) drive('0, '0);
		foreach (written[i]) begin
			lookup(written[i]);
			lookup(written[i]);
		end
		drain("offset");
		end_test("offset");

		written.delete();
		start = 8'(take_bits(8));
		n = 4 + int'(3'(take_bits(3)));
		write_table(4'(take_bits(4)) | 4'd1, start, n, 1'b0);
		repeat (2) drive('0, '0);
		for (int i = 0; i < 32; i++) begin
			lookup(i);
		end
		drain("mask");
		end_test("mask");

		for (int i = 0; i < 200; i++) begin
			drive('0, random_pkt(2'(take_bits(2)) != 2'd0));
		end
		drain("stream");
		end_test("stream");

		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d lookups",
			tests, failed, checks, errors, seen);
		if (errors == 0 && !timed_out) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: key_extract_sva.sv
`timescale 1ns/1ps
`default_nettype none

module key_extract_sva #(
	parameter logic [key_extract_pkg::STAGE_W-1:0] STAGE_ID  = 5'd0,
	parameter logic [key_extract_pkg::EXID_W-1:0]  KEY_EX_ID = 3'd1
) (
	input wire                              clk,
	input wire                              rst_n,
	input wire key_extract_pkg::ctrl_beat_t ctrl_in,
	input wire key_extract_pkg::ctrl_beat_t ctrl_out,
	input wire key_extract_pkg::pkt_out_t   pkt_out,
	input wire key_extract_pkg::tbl_write_t wr
);

	logic hdr_hit;

	// beat carrying this stage's config header
	assign hdr_hit = ctrl_in.valid
		&& ctrl_in.data[key_extract_pkg::HDR_FLAG_LSB +: 16] == key_extract_pkg::CTRL_FLAG
		&& ctrl_in.data[key_extract_pkg::HDR_MODID_LSB +: 8] == {STAGE_ID, KEY_EX_ID};

	valid_pair: assert property (@(posedge clk) disable iff (!rst_n)
		pkt_out.key_valid == pkt_out.phv_valid)
		else $error("key_valid and phv_valid disagree");

	one_table: assert property (@(posedge clk) disable iff (!rst_n)
		!(wr.wr_off && wr.wr_mask))
		else $error("both tables written in one cycle");

	hdr_consumed: assert property (@(posedge clk) disable iff (!rst_n)
		hdr_hit |=> !ctrl_out.valid)
		else $error("config header was forwarded");

endmodule

bind key_extract_top key_extract_sva #(
	.STAGE_ID  (STAGE_ID),
	.KEY_EX_ID (KEY_EX_ID)
) i_key_extract_sva (
	.clk      (clk),
	.rst_n    (rst_n),
	.ctrl_in  (ctrl_in),
	.ctrl_out (ctrl_out),
	.pkt_out  (pkt_out),
	.wr       (wr)
);

`default_nettype wire

// File: key_extract_top.sv
`timescale 1ns/1ps
`default_nettype none

module key_extract_top #(
	parameter logic [key_extract_pkg::STAGE_W-1:0] STAGE_ID     = 5'd0,
	parameter logic [key_extract_pkg::EXID_W-1:0]  KEY_EX_ID    = 3'd1,
	parameter int                                  TABLE_ADDR_W = 5
) (
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire key_extract_pkg::ctrl_beat_t  ctrl_in,
	input  wire key_extract_pkg::pkt_in_t     pkt_in,
	output key_extract_pkg::ctrl_beat_t       ctrl_out,
	output key_extract_pkg::pkt_out_t         pkt_out
);

	key_extract_pkg::tbl_write_t wr;
	logic [TABLE_ADDR_W-1:0]     rd_addr;
	key_extract_pkg::key_off_t   off_entry;
	key_extract_pkg::key_mask_t  mask_entry;

	// ====================
	// control path
	// ====================
	ctrl_write_fsm #(
		.STAGE_ID  (STAGE_ID),
		.KEY_EX_ID (KEY_EX_ID)
	) i_ctrl_write_fsm (
		.clk      (clk),
		.rst_n    (rst_n),
		.ctrl_in  (ctrl_in),
		.ctrl_out (ctrl_out),
		.wr       (wr)
	);

	// ====================
	// tables
	// ====================
	config_table #(
		.TABLE_ADDR_W (TABLE_ADDR_W),
		.entry_t      (key_extract_pkg::key_off_t)
	) offset_table (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_en    (wr.wr_off),
		.wr_index (wr.index),
		.wr_entry (wr.off),
		.rd_addr  (rd_addr),
		.rd_entry (off_entry)
	);

	config_table #(
		.TABLE_ADDR_W (TABLE_ADDR_W),
		.entry_t      (key_extract_pkg::key_mask_t)
	) mask_table (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_en    (wr.wr_mask),
		.wr_index (wr.index),
		.wr_entry (wr.mask),
		.rd_addr  (rd_addr),
		.rd_entry (mask_entry)
	);

	// ====================
	// lookup pipeline
	// ====================
	key_extractor #(
		.TABLE_ADDR_W (TABLE_ADDR_W)
	) i_key_extractor (
		.clk        (clk),
		.rst_n      (rst_n),
		.pkt_in     (pkt_in),
		.rd_addr    (rd_addr),
		.off_entry  (off_entry),
		.mask_entry (mask_entry),
		.pkt_out    (pkt_out)
	);

endmodule

`default_nettype wire

// File: key_extractor.sv
`timescale 1ns/1ps
`default_nettype none

module key_extractor #(
	parameter int TABLE_ADDR_W = 5
) (
	input  wire                              clk,
	input  wire                              rst_n,
	input  wire key_extract_pkg::pkt_in_t    pkt_in,
	output logic [TABLE_ADDR_W-1:0]          rd_addr,
	input  wire key_extract_pkg::key_off_t   off_entry,
	input  wire key_extract_pkg::key_mask_t  mask_entry,
	output key_extract_pkg::pkt_out_t        pkt_out
);

	key_extract_pkg::phv_t s1_phv;
	logic                  s1_valid;

	key_extract_pkg::key_t key_sel;
	key_extract_pkg::key_t key_masked;

	key_extract_pkg::phv_t s2_phv;
	key_extract_pkg::key_t s2_key;
	logic                  s2_valid;

	// table address straight from the incoming vlan
	assign rd_addr = pkt_in.vlan[key_extract_pkg::VLAN_ADDR_LSB +: TABLE_ADDR_W];

	// ====================
	// stage 1
	// ====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= pkt_in.valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_phv <= pkt_in.phv;
	end

	// ====================
	// stage 2
	// ====================
	always_comb begin
		key_sel.k6_0 = s1_phv.h6[off_entry.sel0];
		key_sel.k6_1 = s1_phv.h6[off_entry.sel1];
		key_sel.k4_0 = s1_phv.h4[off_entry.sel2];
		key_sel.k4_1 = s1_phv.h4[off_entry.sel3];
		key_sel.k2_0 = s1_phv.h2[off_entry.sel4];
		key_sel.k2_1 = s1_phv.h2[off_entry.sel5];
		key_masked   = key_extract_pkg::key_t'(key_sel & mask_entry);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s2_valid <= 1'b0;
		end else begin
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		s2_phv <= s1_phv;
		s2_key <= key_masked;
	end

	// key and phv always leave together
	assign pkt_out = '{
		phv:       s2_phv,
		key:       s2_key,
		phv_valid: s2_valid,
		key_valid: s2_valid
	};

endmodule

`default_nettype wire

// File: ctrl_write_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_write_fsm #(
	parameter logic [key_extract_pkg::STAGE_W-1:0] STAGE_ID  = 5'd0,
	parameter logic [key_extract_pkg::EXID_W-1:0]  KEY_EX_ID = 3'd1
) (
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire key_extract_pkg::ctrl_beat_t  ctrl_in,
	output key_extract_pkg::ctrl_beat_t       ctrl_out,
	output key_extract_pkg::tbl_write_t       wr
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WR_OFF,
		ST_WR_MASK
	} state_t;

	state_t                              state;
	logic                                first;
	logic [key_extract_pkg::IDX_W-1:0]   idx;
	logic                                wr_off;
	logic                                wr_mask;
	key_extract_pkg::key_off_t           off_entry;
	key_extract_pkg::key_mask_t          mask_entry;

	logic [key_extract_pkg::CTRL_DATA_W-1:0] data_swap;
	logic [key_extract_pkg::FLAG_W-1:0]      hdr_flag;
	logic [key_extract_pkg::STAGE_W-1:0]     hdr_stage;
	logic [key_extract_pkg::EXID_W-1:0]      hdr_exid;
	logic [key_extract_pkg::RESV_W-1:0]      hdr_resv;
	logic [key_extract_pkg::IDX_W-1:0]       hdr_index;
	logic                                    hdr_match;

	// ====================
	// header decode
	// ====================
	assign hdr_flag = ctrl_in.data[key_extract_pkg::HDR_FLAG_LSB +: key_extract_pkg::FLAG_W];
	assign hdr_exid = ctrl_in.data[key_extract_pkg::HDR_MODID_LSB +: key_extract_pkg::EXID_W];
	assign hdr_stage = ctrl_in.data[key_extract_pkg::HDR_MODID_LSB + key_extract_pkg::EXID_W
		+: key_extract_pkg::STAGE_W];
	assign hdr_resv = ctrl_in.data[key_extract_pkg::HDR_RESV_LSB +: key_extract_pkg::RESV_W];
	assign hdr_index = ctrl_in.data[key_extract_pkg::HDR_INDEX_LSB +: key_extract_pkg::IDX_W];

	assign hdr_match = ctrl_in.valid && (hdr_flag == key_extract_pkg::CTRL_FLAG)
		&& (hdr_stage == STAGE_ID) && (hdr_exid == KEY_EX_ID);

	// byte 0 of the beat becomes the top byte
	always_comb begin
		for (int b = 0; b < key_extract_pkg::CTRL_DATA_W / 8; b++) begin
			data_swap[key_extract_pkg::CTRL_DATA_W - 8 - 8 * b +: 8] = ctrl_in.data[8 * b +: 8];
		end
	end

	// ====================
	// state machine
	// ====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			first    <= 1'b0;
			idx      <= '0;
			wr_off   <= 1'b0;
			wr_mask  <= 1'b0;
			ctrl_out <= '0;
		end else begin
			wr_off   <= 1'b0;
			wr_mask  <= 1'b0;
			ctrl_out <= '0;
			case (state)
				ST_IDLE: begin
					if (hdr_match) begin
						idx   <= hdr_index;
						first <= 1'b1;
						state <= (hdr_resv == '0) ? ST_WR_OFF : ST_WR_MASK;
					end else begin
						// not ours, pass through untouched
						ctrl_out <= ctrl_in;
					end
				end
				ST_WR_OFF, ST_WR_MASK: begin
					if (ctrl_in.valid) begin
						wr_off  <= (state == ST_WR_OFF);
						wr_mask <= (state == ST_WR_MASK);
						first   <= 1'b0;
						// first data beat keeps the header index
						if (!first) begin
							idx <= idx + 1'b1;
						end
						if (ctrl_in.last) begin
							state <= ST_IDLE;
						end
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// entry payload, taken from the top of the swapped beat
	always_ff @(posedge clk) begin
		if (state == ST_WR_OFF && ctrl_in.valid) begin
			off_entry <= key_extract_pkg::key_off_t'(
				data_swap[key_extract_pkg::CTRL_DATA_W-1 -: $bits(key_extract_pkg::key_off_t)]);
		end
		if (state == ST_WR_MASK && ctrl_in.valid) begin
			mask_entry <= data_swap[key_extract_pkg::CTRL_DATA_W-1 -: key_extract_pkg::KEY_W];
		end
	end

	assign wr = '{
		index:   idx,
		off:     off_entry,
		mask:    mask_entry,
		wr_off:  wr_off,
		wr_mask: wr_mask
	};

endmodule

`default_nettype wire

// File: config_table.sv
`timescale 1ns/1ps
`default_nettype none

module config_table #(
	parameter int  TABLE_ADDR_W = 5,
	parameter type entry_t      = logic [7:0]
) (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    wr_en,
	input  wire [7:0]              wr_index,
	input  wire entry_t            wr_entry,
	input  wire [TABLE_ADDR_W-1:0] rd_addr,
	output entry_t                 rd_entry
);

	localparam int DEPTH = 2 ** TABLE_ADDR_W;

	entry_t mem [DEPTH];

	// read before write on a same-address collision
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
			rd_entry <= '0;
		end else begin
			if (wr_en) begin
				mem[wr_index[TABLE_ADDR_W-1:0]] <= wr_entry;
			end
			rd_entry <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

// File: key_extract_pkg.sv
`default_nettype none

package key_extract_pkg;

	// ====================
	// control bus
	// ====================
	localparam int CTRL_DATA_W = 512;
	localparam int CTRL_USER_W = 128;
	localparam int CTRL_KEEP_W = 64;

	typedef struct packed {
		logic [CTRL_DATA_W-1:0] data;
		logic [CTRL_USER_W-1:0] user;
		logic [CTRL_KEEP_W-1:0] keep;
		logic                   valid;
		logic                   last;
	} ctrl_beat_t;

	// header fields of a control packet
	localparam int HDR_FLAG_LSB  = 320;
	localparam int HDR_MODID_LSB = 368;
	localparam int HDR_RESV_LSB  = 376;
	localparam int HDR_INDEX_LSB = 384;

	localparam int FLAG_W  = 16;
	localparam int EXID_W  = 3;
	localparam int STAGE_W = 5;
	localparam int RESV_W  = 4;
	localparam int IDX_W   = 8;

	localparam logic [FLAG_W-1:0] CTRL_FLAG = 16'hf2f1;

	// ====================
	// packet header vector
	// ====================
	localparam int H6_W     = 48;
	localparam int H4_W     = 32;
	localparam int H2_W     = 16;
	localparam int NUM_CONT = 8;
	localparam int META_W   = 256;
	localparam int SEL_W    = $clog2(NUM_CONT);

	typedef struct packed {
		logic [NUM_CONT-1:0][H6_W-1:0] h6;
		logic [NUM_CONT-1:0][H4_W-1:0] h4;
		logic [NUM_CONT-1:0][H2_W-1:0] h2;
		logic [META_W-1:0]             meta;
	} phv_t;

	localparam int VLAN_W        = 12;
	localparam int VLAN_ADDR_LSB = 4;

	typedef struct packed {
		phv_t              phv;
		logic [VLAN_W-1:0] vlan;
		logic              valid;
	} pkt_in_t;

	// ====================
	// key and tables
	// ====================
	typedef struct packed {
		logic [SEL_W-1:0] sel0;
		logic [SEL_W-1:0] sel1;
		logic [SEL_W-1:0] sel2;
		logic [SEL_W-1:0] sel3;
		logic [SEL_W-1:0] sel4;
		logic [SEL_W-1:0] sel5;
	} key_off_t;

	localparam int KEY_W = 2 * (H6_W + H4_W + H2_W);

	typedef logic [KEY_W-1:0] key_mask_t;

	typedef struct packed {
		logic [H6_W-1:0] k6_0;
		logic [H6_W-1:0] k6_1;
		logic [H4_W-1:0] k4_0;
		logic [H4_W-1:0] k4_1;
		logic [H2_W-1:0] k2_0;
		logic [H2_W-1:0] k2_1;
	} key_t;

	typedef struct packed {
		phv_t phv;
		key_t key;
		logic phv_valid;
		logic key_valid;
	} pkt_out_t;

	typedef struct packed {
		logic [IDX_W-1:0] index;
		key_off_t         off;
		key_mask_t        mask;
		logic             wr_off;
		logic             wr_mask;
	} tbl_write_t;

endpackage

`default_nettype wire
